//--- dmacArb.sv
// Fixed-priority arbiter between the GPU and ordering-table channels, muxing the granted bus to wbMaster
`timescale 1ns/1ns
module dmacArb
   import dmacBusPkg::*;
(
   input  logic CLK,
   input  logic rstN,
   input  logic periReq,
   input  logic otReq,
   input  logic pcrEn2,
   input  logic pcrEn6,
   output logic periGrant,
   output logic otGrant,
   // GPU channel bus
   input  addrT periAddr,
   input  logic periReadReq,
   input  logic periWriteReq,
   input  dataT periWriteData,
   output logic periReadAck,
   output logic periWriteAck,
   output dataT periReadData,
   // Ordering-table channel bus, write only
   input  addrT otAddr,
   input  logic otWriteReq,
   input  dataT otWriteData,
   output logic otWriteAck,
   // Merged bus towards the master
   output addrT mAddr,
   output logic mReadReq,
   output logic mWriteReq,
   output dataT mWriteData,
   input  logic mReadAck,
   input  logic mWriteAck,
   input  dataT mReadData
);

   logic periWin;
   logic otWin;

   // Channel 2 beats channel 6 when both ask in an idle cycle
   assign periWin = periReq & pcrEn2;
   assign otWin   = otReq & pcrEn6 & ~periWin;

   ////////////////////////////////////////////////////////////
   // Grant held until the owner drops its request
   always_ff @(posedge CLK) begin
      if (!rstN) begin
         periGrant <= 1'b0;
         otGrant   <= 1'b0;
      end else if (periGrant) begin
         periGrant <= periReq;
      end else if (otGrant) begin
         otGrant <= otReq;
      end else begin
         periGrant <= periWin;
         otGrant   <= otWin;
      end
   end

   ////////////////////////////////////////////////////////////
   // Bus mux, acks only reach the granted channel
   assign mAddr      = otGrant ? otAddr : periAddr;
   assign mWriteData = otGrant ? otWriteData : periWriteData;
   assign mReadReq   = periGrant & periReadReq;
   assign mWriteReq  = (periGrant & periWriteReq) | (otGrant & otWriteReq);

   assign periReadAck  = periGrant & mReadAck;
   assign periWriteAck = periGrant & mWriteAck;
   assign otWriteAck   = otGrant & mWriteAck;
   assign periReadData = mReadData;

endmodule

//--- dmacBusPkg.sv
// Bus word types and DMA channel numbering, imported by every DMA controller RTL block
package dmacBusPkg;

   ////////////////////////////////////////////////////////////
   // Bus widths

   localparam int addrW = 32;
   localparam int dataW = 32;

   typedef logic [addrW-1:0] addrT;
   typedef logic [dataW-1:0] dataT;

   ////////////////////////////////////////////////////////////
   // Channel numbering, as seen by the register map and PCR

   // GPU peripheral channel
   localparam int gpuCh = 2;
   // Ordering-table clear channel
   localparam int otCh  = 6;

endpackage

//--- dmacOtCh.sv
// Ordering-table clear channel writing a descending chain of link words, under dmacTop
`timescale 1ns/1ns
module dmacOtCh
   import dmacBusPkg::*, dmacRegPkg::*;
(
   input  logic   CLK,
   input  logic   rstN,
   input  logic   tr,
   input  addrT   madr,
   input  bcrWord bcr,
   input  logic   grant,
   output logic   otReq,
   output logic   trClr,
   output addrT   addr,
   output logic   writeReq,
   output dataT   writeData,
   input  logic   writeAck
);

   localparam logic [1:0] sIdle  = 2'd0;
   localparam logic [1:0] sGrant = 2'd1;
   localparam logic [1:0] sWrite = 2'd2;
   localparam logic [1:0] sDone  = 2'd3;

   logic [1:0]  state;
   logic [15:0] wordLeft;
   addrT        curAddr;
   dataT        linkWord;

   // Each entry points at the one below it, the last ends the table
   assign linkWord  = (curAddr - addrT'(4)) & otLinkMask;
   assign writeData = (wordLeft == 16'd1) ? otEndMark : linkWord;
   assign addr      = curAddr;
   assign trClr     = (state == sDone);

   always_ff @(posedge CLK) begin
      if (!rstN) begin
         state    <= sIdle;
         otReq    <= 1'b0;
         writeReq <= 1'b0;
         wordLeft <= '0;
         curAddr  <= '0;
      end else begin
         case (state)
            sIdle: if (tr) begin
               curAddr  <= madr;
               wordLeft <= bcr.cnt.wordCnt;
               if (bcr.cnt.wordCnt == '0) begin
                  state <= sDone;
               end else begin
                  otReq <= 1'b1;
                  state <= sGrant;
               end
            end
            sGrant: if (grant) begin
               writeReq <= 1'b1;
               state    <= sWrite;
            end
            sWrite: if (writeAck) begin
               writeReq <= 1'b0;
               curAddr  <= curAddr - addrT'(4);
               wordLeft <= wordLeft - 16'd1;
               if (wordLeft == 16'd1) begin
                  otReq <= 1'b0;
                  state <= sDone;
               end else begin
                  state <= sGrant;
               end
            end
            default: state <= sIdle;
         endcase
      end
   end

endmodule

//--- dmacPeriCh.sv
// GPU channel copying block-synchronised words between memory and the GPU data port, under dmacTop
`timescale 1ns/1ns
module dmacPeriCh
   import dmacBusPkg::*, dmacRegPkg::*;
#(
   parameter addrT gpuDataAddr = '0
)
(
   input  logic   CLK,
   input  logic   rstN,
   input  logic   tr,
   input  logic   dr,
   input  addrT   madr,
   input  bcrWord bcr,
   input  logic   dmaReq,
   input  logic   grant,
   output logic   periReq,
   output logic   trClr,
   output addrT   addr,
   output logic   readReq,
   output logic   writeReq,
   output dataT   writeData,
   input  logic   readAck,
   input  logic   writeAck,
   input  dataT   readData
);

   localparam logic [2:0] sIdle    = 3'd0;
   localparam logic [2:0] sWaitReq = 3'd1;
   localparam logic [2:0] sGrant   = 3'd2;
   localparam logic [2:0] sRead    = 3'd3;
   localparam logic [2:0] sWrite   = 3'd4;
   localparam logic [2:0] sDone    = 3'd5;

   logic [2:0]  state;
   logic [15:0] blkLeft;
   logic [15:0] wordLeft;
   addrT        memAddr;
   dataT        dataBuf;
   logic        memSide;

   // Memory side is the read with dr set, the write with dr clear
   assign memSide   = (state == sRead) ? dr : ~dr;
   assign addr      = memSide ? memAddr : gpuDataAddr;
   assign writeData = dataBuf;
   assign trClr     = (state == sDone);

   always_ff @(posedge CLK) begin
      if (!rstN) begin
         state    <= sIdle;
         periReq  <= 1'b0;
         readReq  <= 1'b0;
         writeReq <= 1'b0;
         blkLeft  <= '0;
         wordLeft <= '0;
         memAddr  <= '0;
      end else begin
         case (state)
            sIdle: if (tr) begin
               memAddr  <= madr;
               blkLeft  <= bcr.blk.blkCnt;
               wordLeft <= bcr.blk.blkSize;
               if (bcr.blk.blkCnt == '0 || bcr.blk.blkSize == '0)
                  state <= sDone;
               else
                  state <= sWaitReq;
            end
            // Each block waits for the GPU to ask
            sWaitReq: if (dmaReq) begin
               periReq <= 1'b1;
               state   <= sGrant;
            end
            sGrant: if (grant) begin
               readReq <= 1'b1;
               state   <= sRead;
            end
            sRead: if (readAck) begin
               readReq  <= 1'b0;
               writeReq <= 1'b1;
               state    <= sWrite;
            end
            sWrite: if (writeAck) begin
               writeReq <= 1'b0;
               memAddr  <= memAddr + addrT'(4);
               if (wordLeft == 16'd1) begin
                  periReq  <= 1'b0;
                  blkLeft  <= blkLeft - 16'd1;
                  wordLeft <= bcr.blk.blkSize;
                  state    <= (blkLeft == 16'd1) ? sDone : sWaitReq;
               end else begin
                  wordLeft <= wordLeft - 16'd1;
                  readReq  <= 1'b1;
                  state    <= sRead;
               end
            end
            default: state <= sIdle;
         endcase
      end
   end

   // Word in flight between its read and its write
   always_ff @(posedge CLK) begin
      if (readAck)
         dataBuf <= readData;
   end

endmodule

//--- dmacRegPkg.sv
// Register map of the DMA controller, imported by the register block, the channels and the testbench
package dmacRegPkg;

   ////////////////////////////////////////////////////////////
   // Offsets within the 256-byte register window

   // Channel n register block sits at chBaseOff + 16 * n
   localparam logic [7:0] chBaseOff = 8'h80;
   localparam int         chStride  = 16;

   localparam logic [7:0] madrOff = 8'h00;
   localparam logic [7:0] bcrOff  = 8'h04;
   localparam logic [7:0] chcrOff = 8'h08;
   localparam logic [7:0] pcrOff  = 8'hF0;

   function automatic logic [7:0] regOff(int ch, logic [7:0] off);
      return chBaseOff + 8'(ch * chStride) + off;
   endfunction

   ////////////////////////////////////////////////////////////
   // CHCR and PCR bits

   // Direction, 1 = memory to peripheral
   localparam int chcrDrBit = 0;
   localparam int chcrTrBit = 24;

   function automatic int pcrEnBit(int ch);
      return 4 * ch + 3;
   endfunction

   ////////////////////////////////////////////////////////////
   // BCR word, block view for the peripheral channel and
   // count view for the ordering-table channel
   typedef union packed {
      struct packed {
         logic [15:0] blkCnt;
         logic [15:0] blkSize;
      } blk;
      struct packed {
         logic [15:0] rsvd;
         logic [15:0] wordCnt;
      } cnt;
   } bcrWord;

   // Ordering table terminator and link mask
   localparam logic [31:0] otEndMark  = 32'h00FF_FFFF;
   localparam logic [31:0] otLinkMask = 32'h00FF_FFFF;

endpackage

//--- dmacRegs.sv
// Wishbone register slave holding channel 2 and 6 configuration and the PCR, instantiated by dmacTop
`timescale 1ns/1ns
module dmacRegs
   import dmacBusPkg::*, dmacRegPkg::*;
(
   input  logic               CLK,
   input  logic               rstN,
   input  addrT               wbRegsAdr,
   input  logic               wbRegsCyc,
   input  logic               wbRegsStb,
   input  logic               wbRegsWe,
   input  logic [dataW/8-1:0] wbRegsSel,
   input  dataT               wbRegsDatWr,
   output dataT               wbRegsDatRd,
   output logic               wbRegsAck,
   output logic               wbRegsErr,
   input  logic               trClr2,
   input  logic               trClr6,
   output addrT               madr2,
   output bcrWord             bcr2,
   output logic               dr2,
   output logic               tr2,
   output addrT               madr6,
   output bcrWord             bcr6,
   output logic               tr6,
   output logic               pcrEn2,
   output logic               pcrEn6
);

   localparam logic [7:0] madr2Off = regOff(gpuCh, madrOff);
   localparam logic [7:0] bcr2Off  = regOff(gpuCh, bcrOff);
   localparam logic [7:0] chcr2Off = regOff(gpuCh, chcrOff);
   localparam logic [7:0] madr6Off = regOff(otCh, madrOff);
   localparam logic [7:0] bcr6Off  = regOff(otCh, bcrOff);
   localparam logic [7:0] chcr6Off = regOff(otCh, chcrOff);

   dataT       pcr;
   dataT       rdMux;
   logic       regHit;
   logic       regAcc;
   logic       wrEn;
   logic [7:0] regOff8;

   // Write only the byte lanes selected by SEL
   function automatic dataT byteMerge(dataT cur, dataT wr, logic [dataW/8-1:0] sel);
      dataT res;
      res = cur;
      for (int i = 0; i < dataW / 8; i++) begin
         if (sel[i])
            res[8*i +: 8] = wr[8*i +: 8];
      end
      return res;
   endfunction

   assign regOff8 = wbRegsAdr[7:0];
   assign regAcc  = wbRegsCyc & wbRegsStb;
   assign wrEn    = regAcc & wbRegsWe & regHit;

   assign pcrEn2 = pcr[pcrEnBit(gpuCh)];
   assign pcrEn6 = pcr[pcrEnBit(otCh)];

   ////////////////////////////////////////////////////////////
   // Offset decode and read mux
   always_comb begin
      regHit = 1'b1;
      rdMux  = '0;
      case (regOff8)
         madr2Off: rdMux = madr2;
         bcr2Off:  rdMux = bcr2;
         chcr2Off: begin
            rdMux[chcrDrBit] = dr2;
            rdMux[chcrTrBit] = tr2;
         end
         madr6Off: rdMux = madr6;
         bcr6Off:  rdMux = bcr6;
         chcr6Off: rdMux[chcrTrBit] = tr6;
         pcrOff:   rdMux = pcr;
         default:  regHit = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Register updates and bus response
   always_ff @(posedge CLK) begin
      if (!rstN) begin
         wbRegsAck   <= 1'b0;
         wbRegsErr   <= 1'b0;
         wbRegsDatRd <= '0;
         madr2       <= '0;
         bcr2        <= '0;
         dr2         <= 1'b0;
         tr2         <= 1'b0;
         madr6       <= '0;
         bcr6        <= '0;
         tr6         <= 1'b0;
         pcr         <= '0;
      end else begin
         wbRegsAck   <= regAcc & regHit;
         wbRegsErr   <= regAcc & ~regHit;
         wbRegsDatRd <= rdMux;
         // Done pulses first, so a CPU write to TR in the same cycle wins
         if (trClr2)
            tr2 <= 1'b0;
         if (trClr6)
            tr6 <= 1'b0;
         if (wrEn) begin
            case (regOff8)
               madr2Off: madr2 <= byteMerge(madr2, wbRegsDatWr, wbRegsSel);
               bcr2Off:  bcr2  <= byteMerge(bcr2, wbRegsDatWr, wbRegsSel);
               chcr2Off: begin
                  if (wbRegsSel[chcrDrBit/8])
                     dr2 <= wbRegsDatWr[chcrDrBit];
                  if (wbRegsSel[chcrTrBit/8])
                     tr2 <= wbRegsDatWr[chcrTrBit];
               end
               madr6Off: madr6 <= byteMerge(madr6, wbRegsDatWr, wbRegsSel);
               bcr6Off:  bcr6  <= byteMerge(bcr6, wbRegsDatWr, wbRegsSel);
               chcr6Off: begin
                  if (wbRegsSel[chcrTrBit/8])
                     tr6 <= wbRegsDatWr[chcrTrBit];
               end
               default:  pcr   <= byteMerge(pcr, wbRegsDatWr, wbRegsSel);
            endcase
         end
      end
   end

endmodule

//--- dmacTb.sv
// Testbench for dmacTop with a register driver, Wishbone memory and GPU port model, run as top
`timescale 1ns/1ns
module dmacTb
   import dmacBusPkg::*, dmacRegPkg::*;
;

   localparam addrT gpuAddr = 32'h1F80_1810;
   localparam addrT madr2A  = 32'h80 + 16 * gpuCh + 32'(madrOff);
   localparam addrT bcr2A   = 32'h80 + 16 * gpuCh + 32'(bcrOff);
   localparam addrT chcr2A  = 32'h80 + 16 * gpuCh + 32'(chcrOff);
   localparam addrT madr6A  = 32'h80 + 16 * otCh + 32'(madrOff);
   localparam addrT bcr6A   = 32'h80 + 16 * otCh + 32'(bcrOff);
   localparam addrT chcr6A  = 32'h80 + 16 * otCh + 32'(chcrOff);
   localparam addrT pcrA    = 32'h0000_00F0;

   logic       CLK, rstN, dmaReq, dmaAck;
   addrT       wbRegsAdr, wbAdr;
   logic       wbRegsCyc, wbRegsStb, wbRegsWe, wbRegsAck, wbRegsErr;
   logic [3:0] wbRegsSel, wbSel;
   dataT       wbRegsDatWr, wbRegsDatRd, wbDatWr, wbDatRd;
   logic       wbCyc, wbStb, wbWe, wbAck, wbStall, wbErr;

   integer seed = 3816;
   int     errCnt = 0;
   int     testsRun = 0;
   int     testsFailed = 0;
   int     errAtStart;

   // Memory, GPU port and access log
   dataT   mem [addrT];
   dataT   gpuIn[$];
   dataT   gpuOut[$];
   addrT   logAddr[$], expAddr[$];
   logic   logWe[$], expWe[$];
   dataT   logData[$], expData[$];

   logic   pending;
   int     ackDelay;
   addrT   pendAddr;
   logic   pendWe;
   dataT   pendData;

   tbClkGen clkGen (.CLK(CLK));

   dmacTop #(.gpuDataAddr(gpuAddr)) u_dut (
      .CLK, .rstN,
      .wbRegsAdr, .wbRegsCyc, .wbRegsStb, .wbRegsWe, .wbRegsSel,
      .wbRegsDatWr, .wbRegsDatRd, .wbRegsAck, .wbRegsErr,
      .wbAdr, .wbCyc, .wbStb, .wbWe, .wbSel, .wbDatWr,
      .wbAck, .wbStall, .wbErr, .wbDatRd,
      .dmaReq, .dmaAck
   );

   ////////////////////////////////////////////////////////////
   // Reference model

   // Unwritten memory returns a word built from the whole address
   function automatic dataT memFill(addrT a);
      return {a[15:0], a[31:16]} ^ 32'h5A5A_C3C3;
   endfunction

   function automatic dataT gpuWord(int i);
      return 32'hC0DE_0000 + 32'(i * 32'h0101);
   endfunction

   function automatic void expect1(addrT a, logic we, dataT d);
      expAddr.push_back(a);
      expWe.push_back(we);
      expData.push_back(d);
   endfunction

   // Word k at madr - 4k links to the entry below, last one ends the table
   function automatic void otExpect(addrT madr, int n);
      addrT a;
      for (int k = 0; k < n; k++) begin
         a = madr - addrT'(4 * k);
         expect1(a, 1'b1, (k == n - 1) ? 32'h00FF_FFFF : ((a - 32'd4) & 32'h00FF_FFFF));
      end
   endfunction

   // One read then one write per word, memory address rising by 4
   function automatic void periExpect(addrT madr, int words, logic dr, int gpuBase);
      addrT a;
      for (int i = 0; i < words; i++) begin
         a = madr + addrT'(4 * i);
         if (dr) begin
            expect1(a, 1'b0, memFill(a));
            expect1(gpuAddr, 1'b1, memFill(a));
         end else begin
            expect1(gpuAddr, 1'b0, gpuWord(gpuBase + i));
            expect1(a, 1'b1, gpuWord(gpuBase + i));
         end
      end
   endfunction

   ////////////////////////////////////////////////////////////
   // Wishbone memory model, acceptance seen on the rising edge
   // and the response driven on the falling edge
   initial begin
      wbAck    = 1'b0;
      wbStall  = 1'b0;
      wbDatRd  = '0;
      pending  = 1'b0;
      ackDelay = 0;
      forever begin
         @(posedge CLK);
         if (wbCyc && wbStb && !wbStall && !pending && !wbAck) begin
            checkEq("master SEL", 32'(wbSel), 32'h0000_000F);
            pending  = 1'b1;
            pendAddr = wbAdr;
            pendWe   = wbWe;
            pendData = wbDatWr;
            ackDelay = $random(seed) & 3;
         end
         @(negedge CLK);
         wbAck = 1'b0;
         if (pending) begin
            wbStall = 1'b0;
            if (ackDelay == 0) begin
               serveAccess();
               wbAck   = 1'b1;
               pending = 1'b0;
            end else begin
               ackDelay--;
            end
         end else begin
            wbStall = (($random(seed) & 3) == 0);
         end
      end
   end

   task automatic serveAccess();
      dataT d;
      d = pendData;
      if (pendAddr == gpuAddr) begin
         assert (dmaAck) else begin
            $display("Fail at %0t ns: GPU data access without dmaAck", $time);
            errCnt++;
         end
         if (pendWe)
            gpuOut.push_back(pendData);
         else
            d = (gpuIn.size() > 0) ? gpuIn.pop_front() : 32'h0;
      end else if (pendWe) begin
         mem[pendAddr] = pendData;
      end else begin
         d = mem.exists(pendAddr) ? mem[pendAddr] : memFill(pendAddr);
      end
      wbDatRd = d;
      logAddr.push_back(pendAddr);
      logWe.push_back(pendWe);
      logData.push_back(d);
   endtask

   ////////////////////////////////////////////////////////////
   // Register driver and helpers

   task automatic abortRun(string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic regAccess(addrT a, logic we, logic [3:0] sel, dataT d,
                            output dataT rd, output logic err);
      int n;
      @(negedge CLK);
      wbRegsAdr   = a;
      wbRegsWe    = we;
      wbRegsSel   = sel;
      wbRegsDatWr = d;
      wbRegsCyc   = 1'b1;
      wbRegsStb   = 1'b1;
      @(negedge CLK);
      wbRegsCyc = 1'b0;
      wbRegsStb = 1'b0;
      n = 0;
      while (!wbRegsAck && !wbRegsErr) begin
         if (n == 20)
            abortRun("Register access got neither ACK nor ERR in time");
         @(negedge CLK);
         n++;
      end
      rd  = wbRegsDatRd;
      err = wbRegsErr;
   endtask

   task automatic regWrite(addrT a, dataT d, logic [3:0] sel);
      dataT rd;
      logic err;
      regAccess(a, 1'b1, sel, d, rd, err);
   endtask

   task automatic regRead(addrT a, output dataT rd);
      logic err;
      regAccess(a, 1'b0, 4'hF, 32'h0, rd, err);
      assert (!err) else begin
         $display("Fail at %0t ns: read of offset %h returned ERR", $time, a);
         errCnt++;
      end
   endtask

   task automatic checkEq(string what, dataT got, dataT exp);
      assert (got === exp) else begin
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errCnt++;
      end
   endtask

   task automatic regCheck(addrT a, dataT exp);
      dataT rd;
      regRead(a, rd);
      checkEq($sformatf("register %h", a), rd, exp);
   endtask

   task automatic waitTrClear(addrT chcrA);
      dataT rd;
      int   n;
      n = 0;
      regRead(chcrA, rd);
      while (rd[chcrTrBit]) begin
         if (n == 400)
            abortRun("Transfer never cleared its TR bit");
         regRead(chcrA, rd);
         n++;
      end
   endtask

   task automatic waitGpuWords(int words);
      int n;
      n = 0;
      while (gpuOut.size() < words) begin
         if (n == 2000)
            abortRun("GPU port did not receive the expected words");
         @(posedge CLK);
         n++;
      end
   endtask

   // Compare process for the access log
   task automatic compareLog();
      assert (logAddr.size() == expAddr.size()) else begin
         $display("Fail at %0t ns: %0d accesses logged, expected %0d",
                  $time, logAddr.size(), expAddr.size());
         errCnt++;
      end
      for (int i = 0; i < logAddr.size() && i < expAddr.size(); i++) begin
         checkEq($sformatf("access %0d address", i), logAddr[i], expAddr[i]);
         checkEq($sformatf("access %0d direction", i), 32'(logWe[i]), 32'(expWe[i]));
         checkEq($sformatf("access %0d data", i), logData[i], expData[i]);
      end
   endtask

   task automatic startTest();
      logAddr.delete();
      logWe.delete();
      logData.delete();
      expAddr.delete();
      expWe.delete();
      expData.delete();
      gpuOut.delete();
      errAtStart = errCnt;
   endtask

   task automatic endTest(string name);
      testsRun++;
      if (errCnt == errAtStart) begin
         $display("Test %s: passed", name);
      end else begin
         testsFailed++;
         $display("Test %s: failed with %0d errors", name, errCnt - errAtStart);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   initial begin
      dataT rd;
      logic err;
      int   logLen;
      int   firstOt;
      rstN = 1'b0;
      dmaReq = 1'b0;
      wbRegsAdr = '0;
      wbRegsCyc = 1'b0;
      wbRegsStb = 1'b0;
      wbRegsWe = 1'b0;
      wbRegsSel = '0;
      wbRegsDatWr = '0;
      wbErr = 1'b0;
      repeat (16) @(posedge CLK);
      @(negedge CLK);
      rstN = 1'b1;

      // Register readback, SEL masking and an unmapped offset
      startTest();
      regWrite(madr2A, 32'h1234_5678, 4'hF);
      regCheck(madr2A, 32'h1234_5678);
      regWrite(bcr2A, 32'hAABB_CCDD, 4'b0101);
      regCheck(bcr2A, 32'h00BB_00DD);
      regWrite(chcr2A, 32'h0100_0001, 4'b0001);
      regCheck(chcr2A, 32'h0000_0001);
      regWrite(pcrA, 32'hFFFF_FFFF, 4'b0010);
      regCheck(pcrA, 32'h0000_FF00);
      regWrite(madr6A, 32'h0000_ABCD, 4'hF);
      regCheck(madr6A, 32'h0000_ABCD);
      regAccess(32'h40, 1'b1, 4'hF, 32'hFFFF_FFFF, rd, err);
      assert (err) else begin
         $display("Unmapped offset was acknowledged instead of returning ERR");
         errCnt++;
      end
      regCheck(madr2A, 32'h1234_5678);
      regCheck(pcrA, 32'h0000_FF00);
      regWrite(pcrA, 32'h0, 4'hF);
      regWrite(bcr2A, 32'h0, 4'hF);
      endTest("1 registers");

      // Ordering-table clear of 8 entries
      startTest();
      otExpect(32'h0000_4FFC, 8);
      regWrite(pcrA, 32'h0800_0000, 4'hF);
      regWrite(madr6A, 32'h0000_4FFC, 4'hF);
      regWrite(bcr6A, 32'd8, 4'hF);
      regWrite(chcr6A, 32'h0100_0000, 4'hF);
      waitTrClear(chcr6A);
      for (int k = 0; k < 8; k++)
         checkEq($sformatf("table entry %0d", k), mem[32'h4FFC - 4 * k], expData[k]);
      compareLog();
      endTest("2 ordering table");

      // Memory to GPU, 3 blocks of 4 words, one dmaReq pulse per block
      startTest();
      periExpect(32'h0000_1000, 12, 1'b1, 0);
      regWrite(pcrA, 32'h0000_0800, 4'hF);
      regWrite(madr2A, 32'h0000_1000, 4'hF);
      regWrite(bcr2A, 32'h0003_0004, 4'hF);
      regWrite(chcr2A, 32'h0100_0001, 4'hF);
      for (int b = 0; b < 3; b++) begin
         repeat (2) @(negedge CLK);
         dmaReq = 1'b1;
         @(negedge CLK);
         dmaReq = 1'b0;
         waitGpuWords(4 * (b + 1));
         logLen = logAddr.size();
         repeat (40) @(posedge CLK);
         assert (logAddr.size() == logLen) else begin
            $display("Fail at %0t ns: access while dmaReq was low", $time);
            errCnt++;
         end
      end
      waitTrClear(chcr2A);
      for (int i = 0; i < 12; i++)
         checkEq($sformatf("GPU word %0d", i), gpuOut[i], memFill(32'h1000 + 4 * i));
      compareLog();
      endTest("3 memory to GPU");

      // GPU to memory, 2 blocks of 3 words
      startTest();
      for (int i = 0; i < 6; i++)
         gpuIn.push_back(gpuWord(i));
      periExpect(32'h0000_2000, 6, 1'b0, 0);
      regWrite(madr2A, 32'h0000_2000, 4'hF);
      regWrite(bcr2A, 32'h0002_0003, 4'hF);
      dmaReq = 1'b1;
      regWrite(chcr2A, 32'h0100_0000, 4'hF);
      waitTrClear(chcr2A);
      dmaReq = 1'b0;
      for (int i = 0; i < 6; i++)
         checkEq($sformatf("memory word %0d", i), mem[32'h2000 + 4 * i], gpuWord(i));
      compareLog();
      endTest("4 GPU to memory");

      // Channel 6 held off by its PCR enable
      startTest();
      otExpect(32'h0000_6FFC, 5);
      regWrite(pcrA, 32'h0, 4'hF);
      regWrite(madr6A, 32'h0000_6FFC, 4'hF);
      regWrite(bcr6A, 32'd5, 4'hF);
      regWrite(chcr6A, 32'h0100_0000, 4'hF);
      repeat (200) @(posedge CLK);
      assert (logAddr.size() == 0) else begin
         $display("Fail at %0t ns: access with the channel disabled", $time);
         errCnt++;
      end
      regWrite(pcrA, 32'h0800_0000, 4'hF);
      waitTrClear(chcr6A);
      compareLog();
      endTest("5 enable gating");

      // Both channels started together, channel 2 first
      startTest();
      periExpect(32'h0000_7000, 4, 1'b1, 0);
      otExpect(32'h0000_8FFC, 4);
      regWrite(pcrA, 32'h0, 4'hF);
      regWrite(madr2A, 32'h0000_7000, 4'hF);
      regWrite(bcr2A, 32'h0001_0004, 4'hF);
      regWrite(madr6A, 32'h0000_8FFC, 4'hF);
      regWrite(bcr6A, 32'd4, 4'hF);
      dmaReq = 1'b1;
      regWrite(chcr2A, 32'h0100_0001, 4'hF);
      regWrite(chcr6A, 32'h0100_0000, 4'hF);
      // Both requests wait on their enables, so the arbiter sees them in one cycle
      regWrite(pcrA, 32'h0800_0800, 4'hF);
      waitTrClear(chcr2A);
      waitTrClear(chcr6A);
      dmaReq = 1'b0;
      firstOt = logAddr.size();
      for (int i = logAddr.size() - 1; i >= 0; i--) begin
         if (logAddr[i][31:12] == 20'h00008)
            firstOt = i;
      end
      assert (firstOt >= 8) else begin
         $display("Fail at %0t ns: table access %0d before GPU block done", $time, firstOt);
         errCnt++;
      end
      compareLog();
      endTest("6 priority");

      $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errCnt);
      if (errCnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- dmacTop.sv
// DMA controller top level joining registers, arbiter, GPU and ordering-table channels and bus master
`timescale 1ns/1ns
module dmacTop
   import dmacBusPkg::*, dmacRegPkg::*;
#(
   parameter addrT gpuDataAddr = 32'h1F80_1810
)
(
   input  logic               CLK,
   input  logic               rstN,
   // Register slave port
   input  addrT               wbRegsAdr,
   input  logic               wbRegsCyc,
   input  logic               wbRegsStb,
   input  logic               wbRegsWe,
   input  logic [dataW/8-1:0] wbRegsSel,
   input  dataT               wbRegsDatWr,
   output dataT               wbRegsDatRd,
   output logic               wbRegsAck,
   output logic               wbRegsErr,
   // Master port
   output addrT               wbAdr,
   output logic               wbCyc,
   output logic               wbStb,
   output logic               wbWe,
   output logic [dataW/8-1:0] wbSel,
   output dataT               wbDatWr,
   input  logic               wbAck,
   input  logic               wbStall,
   input  logic               wbErr,
   input  dataT               wbDatRd,
   // GPU DMA pins
   input  logic               dmaReq,
   output logic               dmaAck
);

   addrT   madr2, madr6;
   bcrWord bcr2, bcr6;
   logic   dr2, tr2, tr6, pcrEn2, pcrEn6, trClr2, trClr6;
   logic   periReq, otReq, periGrant, otGrant;

   addrT   periAddr, otAddr, mAddr;
   dataT   periWriteData, periReadData, otWriteData, mWriteData, mReadData;
   logic   periReadReq, periWriteReq, periReadAck, periWriteAck;
   logic   otWriteReq, otWriteAck;
   logic   mReadReq, mWriteReq, mReadAck, mWriteAck;

   assign dmaAck = periGrant;

   ////////////////////////////////////////////////////////////
   // Configuration registers
   dmacRegs regsInst (
      .CLK, .rstN,
      .wbRegsAdr, .wbRegsCyc, .wbRegsStb, .wbRegsWe, .wbRegsSel,
      .wbRegsDatWr, .wbRegsDatRd, .wbRegsAck, .wbRegsErr,
      .trClr2, .trClr6,
      .madr2, .bcr2, .dr2, .tr2, .madr6, .bcr6, .tr6, .pcrEn2, .pcrEn6
   );

   ////////////////////////////////////////////////////////////
   // Arbiter between channel 2 and channel 6
   dmacArb arbInst (
      .CLK, .rstN, .periReq, .otReq, .pcrEn2, .pcrEn6, .periGrant, .otGrant,
      .periAddr, .periReadReq, .periWriteReq, .periWriteData,
      .periReadAck, .periWriteAck, .periReadData,
      .otAddr, .otWriteReq, .otWriteData, .otWriteAck,
      .mAddr, .mReadReq, .mWriteReq, .mWriteData, .mReadAck, .mWriteAck, .mReadData
   );

   ////////////////////////////////////////////////////////////
   // Channels
   dmacPeriCh #(.gpuDataAddr(gpuDataAddr)) periInst (
      .CLK, .rstN, .tr(tr2), .dr(dr2), .madr(madr2), .bcr(bcr2),
      .dmaReq, .grant(periGrant), .periReq, .trClr(trClr2),
      .addr(periAddr), .readReq(periReadReq), .writeReq(periWriteReq),
      .writeData(periWriteData), .readAck(periReadAck), .writeAck(periWriteAck),
      .readData(periReadData)
   );

   dmacOtCh otInst (
      .CLK, .rstN, .tr(tr6), .madr(madr6), .bcr(bcr6), .grant(otGrant),
      .otReq, .trClr(trClr6),
      .addr(otAddr), .writeReq(otWriteReq), .writeData(otWriteData),
      .writeAck(otWriteAck)
   );

   ////////////////////////////////////////////////////////////
   // Wishbone master
   wbMaster masterInst (
      .CLK, .rstN,
      .addr(mAddr), .readReq(mReadReq), .writeReq(mWriteReq), .writeData(mWriteData),
      .readAck(mReadAck), .writeAck(mWriteAck), .readData(mReadData),
      .wbAdr, .wbCyc, .wbStb, .wbWe, .wbSel, .wbDatWr,
      .wbAck, .wbStall, .wbErr, .wbDatRd
   );

endmodule

//--- files.f
dmacBusPkg.sv
dmacRegPkg.sv
dmacRegs.sv
dmacArb.sv
dmacPeriCh.sv
dmacOtCh.sv
wbMaster.sv
dmacTop.sv
tbClkGen.sv
dmacTb.sv

//--- run.sh
#!/bin/sh
# Build and run the DMA controller testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -f files.f --top-module dmacTb -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation finished: PASS" sim.log

//--- tbClkGen.sv
// Testbench clock source for the DMA controller testbench, 20 ns period
`timescale 1ns/1ns
module tbClkGen (
   output logic CLK
);

   initial begin
      CLK = 1'b0;
   end

   always begin
      #10 CLK = ~CLK;
   end

endmodule

//--- wbMaster.sv
// Single-beat pipelined Wishbone master serving the arbitrated DMA channel bus, under dmacTop
`timescale 1ns/1ns
module wbMaster
   import dmacBusPkg::*;
(
   input  logic               CLK,
   input  logic               rstN,
   input  addrT               addr,
   input  logic               readReq,
   input  logic               writeReq,
   input  dataT               writeData,
   output logic               readAck,
   output logic               writeAck,
   output dataT               readData,
   output addrT               wbAdr,
   output logic               wbCyc,
   output logic               wbStb,
   output logic               wbWe,
   output logic [dataW/8-1:0] wbSel,
   output dataT               wbDatWr,
   input  logic               wbAck,
   input  logic               wbStall,
   input  logic               wbErr,
   input  dataT               wbDatRd
);

   localparam logic idleSt = 1'b0;
   localparam logic busySt = 1'b1;

   logic state;
   logic startReq;

   // The requester still holds its request during the ack cycle
   assign startReq = (state == idleSt) && (readReq || writeReq) && !(readAck || writeAck);
   assign wbCyc    = (state == busySt);
   assign wbSel    = '1;

   always_ff @(posedge CLK) begin
      if (!rstN) begin
         state    <= idleSt;
         wbStb    <= 1'b0;
         wbWe     <= 1'b0;
         readAck  <= 1'b0;
         writeAck <= 1'b0;
      end else begin
         readAck  <= 1'b0;
         writeAck <= 1'b0;
         case (state)
            idleSt: if (startReq) begin
               state <= busySt;
               wbStb <= 1'b1;
               wbWe  <= writeReq;
            end
            default: begin
               if (!wbStall)
                  wbStb <= 1'b0;
               // ERR ends the access the same way as ACK
               if (wbAck || wbErr) begin
                  state    <= idleSt;
                  wbStb    <= 1'b0;
                  readAck  <= ~wbWe;
                  writeAck <= wbWe;
               end
            end
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (startReq) begin
         wbAdr   <= addr;
         wbDatWr <= writeData;
      end
      if (wbCyc && wbAck)
         readData <= wbDatRd;
   end

endmodule
